//--- source/cpu10_macros.svh
`ifndef CPU10_MACROS_SVH
`define CPU10_MACROS_SVH

// Core widths, all fixed by the 10-bit instruction format
`define CPU10_WORD_W 10  // Data word and instruction width
`define CPU10_NREGS  4   // R0..R3, R0 reads zero
`define CPU10_IMM_W  5   // Signed immediate of OP_LI
`define CPU10_OP_W   3   // Opcode field, also ALU control

`endif

//--- source/cpu10_isa_pkg.sv
`include "cpu10_macros.svh"

package cpu10_isa_pkg;

    // Raw instruction as streamed in by the host
    typedef logic [`CPU10_WORD_W-1:0] instr_t;

    // Opcode field doubles as ALU control
    typedef enum logic [`CPU10_OP_W-1:0] {
        OP_ADD  = 3'b000,  // A + B
        OP_SUB  = 3'b001,  // A - B
        OP_SLT  = 3'b010,  // Bit 9 of A - B
        OP_NAND = 3'b011,  // ~(A & B)
        OP_SLR  = 3'b100,  // A >> 1
        OP_SLL  = 3'b101,  // A << 1
        OP_HALT = 3'b110,  // Zero result, halt flag
        OP_LI   = 3'b111   // Load immediate, rewritten to ADD by the decoder
    } alu_op_e;

    // Decoder FSM
    typedef enum logic {
        DEC_RUN,      // Accepting strobes
        DEC_STOPPED   // HALT seen, strobes dropped until reset
    } dec_state_e;

endpackage

//--- source/cpu10_data_pkg.sv
`include "cpu10_macros.svh"

package cpu10_data_pkg;

    // One datapath word, operands, results and register contents
    typedef logic [`CPU10_WORD_W-1:0] word_t;

    // Register index
    typedef logic [$clog2(`CPU10_NREGS)-1:0] reg_addr_t;

    // OP_LI immediate, two's complement
    typedef logic [`CPU10_IMM_W-1:0] imm_t;

    // Sign extension of the immediate to a full word
    localparam int IMM_EXT_W = `CPU10_WORD_W - `CPU10_IMM_W;

endpackage

//--- source/ripple_carry_adder_10.sv
`timescale 1ns/10ps
`include "cpu10_macros.svh"

module ripple_carry_adder_10 import cpu10_data_pkg::*; (
    input  word_t A,
    input  word_t B,
    input  logic  cin,
    output word_t sum,
    output logic  cout
);

    logic [`CPU10_WORD_W:0] carry;  // carry[i] enters bit i

    assign carry[0] = cin;
    assign cout     = carry[`CPU10_WORD_W];

    // One full-adder cell per bit, carry ripples upward
    genvar i;
    generate
        for (i = 0; i < `CPU10_WORD_W; i = i + 1) begin : fa_cell
            logic p;  // Propagate
            logic g;  // Generate
            logic t;  // Carry through propagate
            xor u_xor_p (p, A[i], B[i]);
            xor u_xor_s (sum[i], p, carry[i]);
            and u_and_g (g, A[i], B[i]);
            and u_and_t (t, p, carry[i]);
            or  u_or_c  (carry[i+1], g, t);
        end
    endgenerate

endmodule

//--- source/alu.sv
`timescale 1ns/10ps

module alu import cpu10_data_pkg::*, cpu10_isa_pkg::*; (
    input  word_t   a,         // From R[rs]
    input  word_t   b,         // From R[rt] or immediate
    input  alu_op_e alu_ctrl,
    output word_t   result,
    output logic    halt
);

    word_t add_result;
    word_t sub_result;
    word_t b_inv;       // ~B for the subtractor
    word_t nand_result;
    word_t slr_result;
    word_t sll_result;
    word_t slt_result;

    assign b_inv = ~b;

    // A + B, carry out not needed
    ripple_carry_adder_10 adder_inst (
        .A   (a),
        .B   (b),
        .cin (1'b0),
        .sum (add_result),
        .cout()
    );

    // A - B as A + ~B + 1
    ripple_carry_adder_10 subtractor_inst (
        .A   (a),
        .B   (b_inv),
        .cin (1'b1),
        .sum (sub_result),
        .cout()
    );

    assign nand_result = ~(a & b);
    assign slr_result  = a >> 1;   // Zero fill at the top
    assign sll_result  = a << 1;   // Zero fill at the bottom

    // Sign bit of the wrapped difference, not a true signed compare
    assign slt_result = sub_result[9] ? word_t'(1) : '0;

    always_comb begin
        halt = 1'b0;
        case (alu_ctrl)
            OP_ADD:  result = add_result;
            OP_SUB:  result = sub_result;
            OP_SLT:  result = slt_result;
            OP_NAND: result = nand_result;
            OP_SLR:  result = slr_result;
            OP_SLL:  result = sll_result;
            OP_HALT: begin
                result = '0;
                halt   = 1'b1;  // Writeback latches halted from this
            end
            default: result = '0;  // OP_LI never reaches here
        endcase
    end

    // Writeback relies on a halting op committing nothing
    always_comb begin
        if (halt) assert (result == '0) else $error("alu: HALT with nonzero result");
    end

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/10ps
`include "cpu10_macros.svh"

module instr_decoder import cpu10_data_pkg::*, cpu10_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,  // One-cycle host strobe
    input  instr_t    instr,
    output logic      ex_valid,
    output alu_op_e   ex_op,
    output reg_addr_t ex_rs,
    output reg_addr_t ex_rt,
    output reg_addr_t ex_rd,
    output logic      ex_use_imm,   // Select immediate as ALU B
    output word_t     ex_imm_word
);

    dec_state_e state;
    alu_op_e    in_op;
    imm_t       in_imm;
    logic       accept;  // Strobe taken this cycle

    assign in_op  = alu_op_e'(instr[9:7]);
    assign in_imm = instr[`CPU10_IMM_W-1:0];
    assign accept = instr_valid && (state == DEC_RUN);

    // FSM and valid
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DEC_RUN;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= accept;
            if (accept && in_op == OP_HALT)
                state <= DEC_STOPPED;  // Sticky until reset
        end
    end

    // Field registers, loaded only on an accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_rt       <= instr[4:3];
            ex_imm_word <= {{IMM_EXT_W{in_imm[`CPU10_IMM_W-1]}}, in_imm};
            if (in_op == OP_LI) begin
                ex_op      <= OP_ADD;       // LI is R0 + imm
                ex_rs      <= '0;
                ex_rd      <= instr[6:5];   // LI keeps rd where rs normally sits
                ex_use_imm <= 1'b1;
            end else begin
                ex_op      <= in_op;
                ex_rs      <= instr[6:5];
                ex_rd      <= instr[2:1];   // Bit 0 unused
                ex_use_imm <= 1'b0;
            end
        end
    end

    // Nothing issues after the cycle that carried the HALT
    assert property (@(posedge clk) disable iff (rst) state == DEC_STOPPED |=> !ex_valid);

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps
`include "cpu10_macros.svh"

module reg_file import cpu10_data_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      we,       // From writeback, valid and not HALT
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`CPU10_NREGS];

    // Async reads, R0 hardwired
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};  // All registers start at zero
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;  // R0 writes dropped here
        end
    end

    // Stored R0 must never pick up a written value
    assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

//--- source/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage import cpu10_data_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  word_t     alu_result,
    input  logic      alu_halt,
    output logic      rf_we,     // Register file write this cycle
    output logic      wb_valid,  // One-cycle pulse per committed write
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      halted     // Level, stays high until reset
);

    // HALT commits nothing
    assign rf_we = ex_valid && !alu_halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            wb_valid <= rf_we;
            if (ex_valid && alu_halt)
                halted <= 1'b1;
        end
    end

    // Report register and data, same edge as the register file write
    always_ff @(posedge clk) begin
        if (rf_we) begin
            wb_rd   <= ex_rd;
            wb_data <= alu_result;
        end
    end

endmodule

//--- source/cpu10_top.sv
`timescale 1ns/10ps

module cpu10_top import cpu10_data_pkg::*, cpu10_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      halted
);

    logic      ex_valid;
    alu_op_e   ex_op;
    reg_addr_t ex_rs;
    reg_addr_t ex_rt;
    reg_addr_t ex_rd;
    logic      ex_use_imm;
    word_t     ex_imm_word;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_halt;
    logic      rf_we;

    instr_decoder u_decoder (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rs(ex_rs), .ex_rt(ex_rt),
        .ex_rd(ex_rd), .ex_use_imm(ex_use_imm), .ex_imm_word(ex_imm_word)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .rs_addr(ex_rs), .rt_addr(ex_rt),
        .rs_data(rs_data), .rt_data(rt_data),
        .we(rf_we), .wr_addr(ex_rd), .wr_data(alu_result)  // Write in the execute cycle
    );

    // B operand, immediate for rewritten LI
    assign alu_b = ex_use_imm ? ex_imm_word : rt_data;

    alu u_alu (
        .a(rs_data), .b(alu_b), .alu_ctrl(ex_op), .result(alu_result), .halt(alu_halt)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_rd(ex_rd),
        .alu_result(alu_result), .alu_halt(alu_halt), .rf_we(rf_we),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int RST_CYCLES = 10;  // Reset length in clock cycles

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;  // Released on a rising edge
    end

endmodule

//--- testbench/tb_cpu10.sv
`timescale 1ns/10ps
`include "cpu10_macros.svh"

module tb_cpu10 import cpu10_data_pkg::*, cpu10_isa_pkg::*; ();

    logic      clk;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      halted;

    word_t     model_regs [`CPU10_NREGS];  // Register state in program order
    reg_addr_t exp_rd_q [$];               // Expected writes in issue order
    word_t     exp_data_q [$];
    int        exp_cycle_q [$];            // Drive edge of each expected write
    int        exp_cycle;
    int        cycles = 0;
    int        issued = 0;
    int        halt_cycle = -1;            // Drive edge of the HALT (-1 until issued)
    bit        halt_seen = 1'b0;
    int        value_errors = 0;
    int        proto_errors = 0;
    int        writes_checked = 0;

    tb_clock_gen u_clk_gen (.clk(clk), .rst(rst));

    cpu10_top u_dut (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .halted(halted)
    );

    always @(posedge clk) cycles <= cycles + 1;

    // Expected word from the ISA rules with every result modulo 1024
    function automatic word_t expected_result(alu_op_e op, word_t a, word_t b, imm_t imm);
        word_t diff;
        diff = word_t'(a - b);
        case (op)
            OP_ADD:  return word_t'(a + b);
            OP_SUB:  return diff;
            OP_SLT:  return diff[`CPU10_WORD_W-1] ? word_t'(1) : word_t'(0);  // Sign of wrapped diff
            OP_NAND: return ~(a & b);
            OP_SLR:  return a >> 1;
            OP_SLL:  return a << 1;
            OP_LI:   return {{(`CPU10_WORD_W-`CPU10_IMM_W){imm[`CPU10_IMM_W-1]}}, imm};
            default: return '0;  // HALT
        endcase
    endfunction

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rd(reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t: wb_rd is R%0d, expected R%0d", $time, got, exp);
        end
    endtask

    // Drive one strobe and queue what the core must report for it
    task automatic issue_instr(alu_op_e op, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                               imm_t imm);
        instr_t word;
        word_t  res;
        if (op == OP_LI)
            word = {op, rd, imm};
        else
            word = {op, rs, rt, rd, 1'b0};  // Bit 0 unused
        res = expected_result(op, model_regs[rs], model_regs[rt], imm);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        issued = issued + 1;
        if (halt_seen) return;  // Dropped by the stopped decoder
        if (op == OP_HALT) begin
            halt_seen  = 1'b1;
            halt_cycle = cycles;
            return;
        end
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_cycle_q.push_back(cycles);
        if (rd != '0)
            model_regs[rd] = res;  // R0 stays zero
    endtask

    task automatic load_imm(reg_addr_t rd, imm_t imm);
        issue_instr(OP_LI, 2'd0, 2'd0, rd, imm);
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d value errors, %0d protocol errors, %0d writes checked",
                 value_errors, proto_errors, writes_checked);
        if (value_errors + proto_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Compare process pops one record per wb_valid pulse
    always @(posedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                proto_errors++;
                $display("Unexpected write report at %0t: R%0d = %0d with nothing outstanding",
                         $time, wb_rd, wb_data);
            end else begin
                check_rd(wb_rd, exp_rd_q.pop_front());
                check_word(wb_data, exp_data_q.pop_front(), "wb_data");
                exp_cycle = exp_cycle_q.pop_front();
                writes_checked++;
                // Pulse set two edges after the drive edge and seen on the third
                if (cycles != exp_cycle + 3) begin
                    proto_errors++;
                    $display("Write report at %0t came %0d cycles after its strobe instead of 2",
                             $time, cycles - exp_cycle - 1);
                end
            end
        end
        if (!rst && halted !== (halt_cycle >= 0 && cycles >= halt_cycle + 3)) begin
            proto_errors++;
            $display("halted is %b at %0t, which does not match a HALT driven at cycle %0d",
                     halted, $time, halt_cycle);
        end
    end

    // Watchdog allows two cycles per issued instruction plus slack
    initial begin
        while (cycles <= issued * 2 + 50) @(posedge clk);
        proto_errors++;
        $display("Timeout: run stopped after %0d cycles with %0d instructions issued",
                 cycles, issued);
        finish_run();
    end

    initial begin
        int unsigned seed_init;
        int          n;
        int          sel;
        seed_init   = $urandom(89992);
        instr_valid = 1'b0;
        instr       = '0;
        for (n = 0; n < `CPU10_NREGS; n++) model_regs[n] = '0;
        @(posedge clk);  // Reset is high by the first edge
        while (rst) @(posedge clk);

        // Immediates and ADD/SUB wrap including 0 - 1
        load_imm(2'd1, 5'd5);
        load_imm(2'd2, 5'h1f);                    // -1 -> 1023
        load_imm(2'd3, 5'h10);                    // -16 -> 1008
        issue_instr(OP_ADD, 2'd1, 2'd2, 2'd3, '0);  // 5 + 1023 wraps to 4
        load_imm(2'd1, 5'd1);
        issue_instr(OP_SUB, 2'd0, 2'd1, 2'd2, '0);  // 0 - 1 = 1023
        issue_instr(OP_ADD, 2'd2, 2'd2, 2'd3, '0);
        issue_instr(OP_SUB, 2'd3, 2'd2, 2'd1, '0);
        idle_cycles(1);

        // SLT on bit 9 plus NAND and shifts
        issue_instr(OP_NAND, 2'd0, 2'd0, 2'd1, '0);  // 1023
        issue_instr(OP_SLR, 2'd1, 2'd0, 2'd1, '0);   // 511
        issue_instr(OP_NAND, 2'd1, 2'd1, 2'd3, '0);  // 512
        issue_instr(OP_SLT, 2'd1, 2'd3, 2'd2, '0);   // 1 where a signed compare gives 0
        issue_instr(OP_SLT, 2'd3, 2'd1, 2'd2, '0);   // 0 where a signed compare gives 1
        load_imm(2'd2, 5'd2);
        issue_instr(OP_SLT, 2'd0, 2'd2, 2'd2, '0);
        issue_instr(OP_NAND, 2'd1, 2'd3, 2'd2, '0);
        issue_instr(OP_SLL, 2'd3, 2'd0, 2'd2, '0);   // Top bit shifted out
        issue_instr(OP_SLL, 2'd1, 2'd0, 2'd1, '0);
        issue_instr(OP_SLR, 2'd1, 2'd0, 2'd2, '0);
        idle_cycles(1);

        // R0 writes reported but dropped
        load_imm(2'd0, 5'd7);
        issue_instr(OP_ADD, 2'd3, 2'd2, 2'd0, '0);  // 512 + 511 aimed at R0
        issue_instr(OP_ADD, 2'd0, 2'd0, 2'd1, '0);
        idle_cycles(1);

        // Dependent chain on consecutive cycles
        load_imm(2'd1, 5'd3);
        issue_instr(OP_ADD, 2'd1, 2'd1, 2'd2, '0);
        issue_instr(OP_ADD, 2'd2, 2'd1, 2'd3, '0);
        issue_instr(OP_SUB, 2'd3, 2'd2, 2'd1, '0);
        issue_instr(OP_SLL, 2'd1, 2'd0, 2'd2, '0);
        issue_instr(OP_ADD, 2'd3, 2'd2, 2'd3, '0);
        idle_cycles(1);

        // Random mix without HALT and with gaps of zero or one cycle
        for (n = 0; n < 300; n++) begin
            sel = $urandom_range(6);
            issue_instr((sel == 6) ? OP_LI : alu_op_e'(sel[2:0]),
                        reg_addr_t'($urandom_range(3)), reg_addr_t'($urandom_range(3)),
                        reg_addr_t'($urandom_range(3)), imm_t'($urandom_range(31)));
            if ($urandom_range(1) == 1) idle_cycles(1);
        end
        idle_cycles(1);

        // HALT followed by strobes that must be dropped
        issue_instr(OP_HALT, 2'd1, 2'd2, 2'd3, '0);
        issue_instr(OP_ADD, 2'd1, 2'd1, 2'd2, '0);
        load_imm(2'd3, 5'd9);
        idle_cycles(1);
        load_imm(2'd1, 5'd4);
        idle_cycles(6);

        if (exp_rd_q.size() != 0) begin
            proto_errors++;
            $display("%0d expected writes were never reported", exp_rd_q.size());
        end
        finish_run();
    end

endmodule

//--- src.f
+incdir+source
source/cpu10_isa_pkg.sv
source/cpu10_data_pkg.sv
source/ripple_carry_adder_10.sv
source/alu.sv
source/instr_decoder.sv
source/reg_file.sv
source/writeback_stage.sv
source/cpu10_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu10.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu10 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_cpu10 -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cpu10 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
